//--- verif/pipe_testdata.txt
// columns: kind_test_arg_word, all hex
// kind 1 instruction, 2 hold for arg cycles, 3 flush offering word, 4 expect r[arg] = word
1_1_00_3c011234  // lui r1, 0x1234
1_1_00_34215678  // ori r1, r1, 0x5678
1_1_00_3c02ffff
1_1_00_34420f0f  // ori r2, r2, 0x0f0f
1_1_00_00221821  // addu r3, r1, r2
1_1_00_00222023  // subu r4, r1, r2
1_1_00_00222824
1_1_00_00223025
1_1_00_00223826  // xor r7, r1, r2
1_1_00_0041402a  // slt r8, r2, r1
1_1_00_00014900  // sll r9, r1, 4
4_1_01_12340000
4_1_01_12345678
4_1_02_ffff0000
4_1_02_ffff0f0f
4_1_03_12336587
4_1_04_12354769
4_1_05_12340608
4_1_06_ffff5f7f
4_1_07_edcb5977
4_1_08_00000001
4_1_09_23456780
1_2_00_240b0005  // addiu r11, r0, 5
1_2_00_256b0007
1_2_00_256bfffd  // addiu r11, r11, -3
1_2_00_256b0100
4_2_0b_00000005
4_2_0b_0000000c
4_2_0b_00000009
4_2_0b_00000109
2_3_02_00000000
1_3_00_256d0001  // addiu r13, r11, 1
2_3_03_00000000
1_3_00_01ad6821  // addu r13, r13, r13
2_3_01_00000000
1_3_00_01ab7023  // subu r14, r13, r11
4_3_0d_0000010a
4_3_0d_00000214
4_3_0e_0000010b
1_4_00_fc000000  // unknown opcode
1_4_00_00221827  // unknown function
1_4_00_24000005  // addiu r0, r0, 5
1_4_00_00017821  // addu r15, r0, r1
4_4_0f_12345678
1_5_00_24100001  // r16 and r17 reach the result stage before the flush
1_5_00_24110002
1_5_00_24120003
1_5_00_24130004
3_5_00_24140005  // flush, r18 r19 r20 dropped
1_5_00_24150006
4_5_10_00000001
4_5_11_00000002
4_5_15_00000006

//--- project.f
+incdir+common
common/pipePkg.sv
decode/registerFile.sv
decode/decodeStage.sv
source/executeStage.sv
source/resultStage.sv
source/pipeCore.sv
verif/pipeCore_assert.sv
verif/pipeCore_tb.sv

//--- Makefile
VERILATOR  := verilator
TOP        := pipeCore_tb
FILELIST   := project.f
BUILD_DIR  := obj_dir
COMMON     := --timing --assert --timescale 1ns/1ns --top-module $(TOP) -f $(FILELIST)
LINT_FLAGS := --lint-only -Wall $(COMMON)
SIM_FLAGS  := --binary -j 0 --Mdir $(BUILD_DIR) $(COMMON)
PASS_TEXT  := PASS: all tests

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS)

sim:
	$(VERILATOR) $(SIM_FLAGS)
	out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- verif/pipeCore_tb.sv
`timescale 1ns/1ns
`include "pipe_macros.svh"

module pipeCore_tb;

	localparam int MAX_RECORDS   = 64;
	localparam int DRAIN_TIMEOUT = 200;

	// record kinds in the data file
	localparam logic [3:0] KIND_INSTR  = 4'd1;
	localparam logic [3:0] KIND_HOLD   = 4'd2;
	localparam logic [3:0] KIND_FLUSH  = 4'd3;
	localparam logic [3:0] KIND_EXPECT = 4'd4;

	logic                       clk;
	logic                       reset;
	logic [`DATA_WIDTH-1:0]     instr;
	logic                       instrValid;
	logic                       hold;
	logic                       flush;
	logic                       wbValid;
	logic [`REG_ADDR_WIDTH-1:0] wbReg;
	logic [`DATA_WIDTH-1:0]     wbData;

	// kind, test, register or count, word
	logic [47:0]                testData [0:MAX_RECORDS-1];
	logic [`REG_ADDR_WIDTH-1:0] expRegQ [$];
	logic [`DATA_WIDTH-1:0]     expDataQ [$];
	logic [`REG_ADDR_WIDTH-1:0] expReg;
	logic [`DATA_WIDTH-1:0]     expData;
	logic [15:0]                lfsr;
	int                         checkCount = 0;
	int                         errorCount = 0;
	int                         testsRun = 0;
	bit                         timedOut;

	pipeCore pipeCore_inst (
		.clk        (clk),
		.reset      (reset),
		.instr      (instr),
		.instrValid (instrValid),
		.hold       (hold),
		.flush      (flush),
		.wbValid    (wbValid),
		.wbReg      (wbReg),
		.wbData     (wbData)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// taps 16 14 13 11
	function automatic logic [15:0] lfsrNext(input logic [15:0] state);
		logic feedback;
		feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
		return {state[14:0], feedback};
	endfunction

	function automatic logic takeBit();
		lfsr = lfsrNext(lfsr);
		return lfsr[0];
	endfunction

	function automatic string testName(input logic [3:0] testNum);
		case (testNum)
			4'd1:    return "alu register ops";
			4'd2:    return "dependent addiu chain";
			4'd3:    return "hold cycles";
			4'd4:    return "bubbles and r0";
			4'd5:    return "flush";
			default: return "unnamed";
		endcase
	endfunction

	// a gap in the last three words before a flush would change which words it hits
	function automatic bit flushAhead(input int idx);
		int seen;
		seen = 0;
		for (int j = idx + 1; j < MAX_RECORDS && seen < 3; j++) begin
			if (testData[j][47:44] == KIND_FLUSH) begin
				return 1'b1;
			end
			if (testData[j][47:44] == KIND_INSTR) begin
				seen++;
			end
		end
		return 1'b0;
	endfunction

	task automatic driveCycle(input logic valid, input logic [`DATA_WIDTH-1:0] word,
			input logic holdLevel, input logic flushLevel);
		instrValid = valid;
		instr      = word;
		hold       = holdLevel;
		flush      = flushLevel;
		@(posedge clk);
		#1;
	endtask

	task automatic randomGap();
		if (takeBit()) begin
			if (takeBit()) begin
				driveCycle(1'b0, '0, 1'b1, 1'b0);
			end else begin
				driveCycle(1'b0, '0, 1'b0, 1'b0);
			end
		end
	endtask

	// all writebacks of a test are queued before its first word goes in
	task automatic queueExpected(input int first);
		logic [3:0] testNum;
		testNum = testData[first][43:40];
		for (int j = first; j < MAX_RECORDS; j++) begin
			if (testData[j][43:40] != testNum) begin
				break;
			end
			if (testData[j][47:44] == KIND_EXPECT) begin
				expRegQ.push_back(testData[j][36:32]);
				expDataQ.push_back(testData[j][31:0]);
			end
		end
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		while (expRegQ.size() != 0 && waited < DRAIN_TIMEOUT) begin
			driveCycle(1'b0, '0, 1'b0, 1'b0);
			waited++;
		end
		if (expRegQ.size() != 0) begin
			$display("timeout: %0d expected writebacks never arrived within %0d cycles",
				expRegQ.size(), waited);
			timedOut = 1'b1;
		end
		// pipeline depth, so that stray writebacks still show up
		for (int i = 0; i < 4; i++) begin
			driveCycle(1'b0, '0, 1'b0, 1'b0);
		end
	endtask

	task automatic endTest(input logic [3:0] testNum, input int startChecks,
			input int startErrors);
		drain();
		testsRun++;
		$display("test %0d %s: %0d writebacks checked, %0d errors", testNum,
			testName(testNum), checkCount - startChecks, errorCount - startErrors);
	endtask

	// writebacks are compared in issue order
	always @(negedge clk) begin
		if (!reset && wbValid) begin
			checkCount++;
			assert (expRegQ.size() != 0) else begin
				$display("writeback to r%0d at %0t ns came when none was expected", wbReg, $time);
				errorCount++;
			end
			if (expRegQ.size() != 0) begin
				expReg  = expRegQ.pop_front();
				expData = expDataQ.pop_front();
				assert (wbReg == expReg && wbData == expData) else begin
					$display("error at %0t ns: writeback r%0d = %h, expected r%0d = %h",
						$time, wbReg, wbData, expReg, expData);
					errorCount++;
				end
			end
		end
	end

	initial begin
		logic [47:0] rec;
		logic [3:0]  currentTest;
		int          startChecks;
		int          startErrors;
		for (int i = 0; i < MAX_RECORDS; i++) begin
			testData[i] = '0;
		end
		$readmemh("verif/pipe_testdata.txt", testData);
		lfsr        = 16'd7;
		timedOut    = 1'b0;
		currentTest = 4'd0;
		startChecks = 0;
		startErrors = 0;
		instr       = '0;
		instrValid  = 1'b0;
		hold        = 1'b0;
		flush       = 1'b0;
		reset       = 1'b1;
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;

		for (int i = 0; i < MAX_RECORDS && !timedOut; i++) begin
			rec = testData[i];
			if (rec[47:44] == 4'd0) begin
				break;
			end
			if (rec[43:40] != currentTest) begin
				if (currentTest != 4'd0) begin
					endTest(currentTest, startChecks, startErrors);
				end
				currentTest = rec[43:40];
				startChecks = checkCount;
				startErrors = errorCount;
				queueExpected(i);
			end
			case (rec[47:44])
				KIND_INSTR: begin
					driveCycle(1'b1, rec[31:0], 1'b0, 1'b0);
					if (!flushAhead(i)) begin
						randomGap();
					end
				end
				KIND_HOLD: begin
					for (int k = 0; k < int'(rec[39:32]); k++) begin
						driveCycle(1'b0, '0, 1'b1, 1'b0);
					end
				end
				KIND_FLUSH: driveCycle(1'b1, rec[31:0], 1'b0, 1'b1);
				default: begin
				end
			endcase
		end
		if (!timedOut && currentTest != 4'd0) begin
			endTest(currentTest, startChecks, startErrors);
		end

		$display("tests %0d, writebacks checked %0d, errors %0d", testsRun, checkCount,
			errorCount);
		if (timedOut || errorCount != 0) begin
			$display("FAIL: see errors above");
		end else begin
			$display("PASS: all tests");
		end
		$finish;
	end

endmodule

//--- verif/pipeCore_assert.sv
`timescale 1ns/1ns
`include "pipe_macros.svh"

module pipeCore_assert (
	input logic                       clk,
	input logic                       reset,
	input logic                       hold,
	input logic                       flush,
	input logic                       decValid,
	input logic [`REG_ADDR_WIDTH-1:0] destReg,
	input logic                       aluValid,
	input logic [`REG_ADDR_WIDTH-1:0] aluDest,
	input logic                       wbValid,
	input logic [`REG_ADDR_WIDTH-1:0] wbReg,
	input logic [`DATA_WIDTH-1:0]     wbData
);

	logic [1:0] sinceReset;

	// saturating count of cycles out of reset
	always_ff @(posedge clk) begin
		if (reset) begin
			sinceReset <= '0;
		end else if (sinceReset != 2'd3) begin
			sinceReset <= sinceReset + 2'd1;
		end
	end

	// every stage keeps its contents across a hold cycle
	holdFreezesStages: assert property (@(posedge clk) disable iff (reset)
		(hold && !flush) |=> ($stable(decValid) && $stable(destReg) && $stable(aluValid)
			&& $stable(aluDest) && $stable(wbReg) && $stable(wbData)))
		else $error("pipeline stage moved while hold was high");

	noWritebackToZero: assert property (@(posedge clk) disable iff (reset)
		wbValid |-> (wbReg != '0))
		else $error("writeback strobe names register 0");

	// stages are still empty this soon after reset
	noEarlyWriteback: assert property (@(posedge clk) disable iff (reset)
		(sinceReset != 2'd3) |-> !wbValid)
		else $error("writeback strobe within three cycles of reset");

endmodule

bind pipeCore pipeCore_assert pipeCore_assert_inst (
	.clk      (clk),
	.reset    (reset),
	.hold     (hold),
	.flush    (flush),
	.decValid (decValid),
	.destReg  (destReg),
	.aluValid (aluValid),
	.aluDest  (aluDest),
	.wbValid  (wbValid),
	.wbReg    (wbReg),
	.wbData   (wbData)
);

//--- source/pipeCore.sv
`timescale 1ns/1ns
`include "pipe_macros.svh"

module pipeCore (
	input  logic                       clk,
	input  logic                       reset,
	input  logic [`DATA_WIDTH-1:0]     instr,
	input  logic                       instrValid,
	input  logic                       hold,
	input  logic                       flush,
	output logic                       wbValid,
	output logic [`REG_ADDR_WIDTH-1:0] wbReg,
	output logic [`DATA_WIDTH-1:0]     wbData
);

	// decode to execute
	logic                       decValid;
	pipePkg::aluOpE             aluOp;
	logic [`REG_ADDR_WIDTH-1:0] destReg;
	logic [`REG_ADDR_WIDTH-1:0] srcA;
	logic [`REG_ADDR_WIDTH-1:0] srcB;
	logic [`DATA_WIDTH-1:0]     operandA;
	logic [`DATA_WIDTH-1:0]     operandB;
	logic [`DATA_WIDTH-1:0]     immediate;
	logic [`SHAMT_WIDTH-1:0]    shamt;
	logic                       useImm;

	// execute to result
	logic                       aluValid;
	logic [`REG_ADDR_WIDTH-1:0] aluDest;
	logic [`DATA_WIDTH-1:0]     aluResult;

	decodeStage decodeStage_inst (
		.clk        (clk),
		.reset      (reset),
		.hold       (hold),
		.flush      (flush),
		.instr      (instr),
		.instrValid (instrValid),
		.wbValid    (wbValid),
		.wbReg      (wbReg),
		.wbData     (wbData),
		.decValid   (decValid),
		.aluOp      (aluOp),
		.destReg    (destReg),
		.srcA       (srcA),
		.srcB       (srcB),
		.operandA   (operandA),
		.operandB   (operandB),
		.immediate  (immediate),
		.shamt      (shamt),
		.useImm     (useImm)
	);

	executeStage executeStage_inst (
		.clk       (clk),
		.reset     (reset),
		.hold      (hold),
		.flush     (flush),
		.decValid  (decValid),
		.aluOp     (aluOp),
		.destReg   (destReg),
		.srcA      (srcA),
		.srcB      (srcB),
		.operandA  (operandA),
		.operandB  (operandB),
		.immediate (immediate),
		.shamt     (shamt),
		.useImm    (useImm),
		.wbValid   (wbValid),
		.wbReg     (wbReg),
		.wbData    (wbData),
		.aluValid  (aluValid),
		.aluDest   (aluDest),
		.aluResult (aluResult)
	);

	resultStage resultStage_inst (
		.clk       (clk),
		.reset     (reset),
		.hold      (hold),
		.flush     (flush),
		.aluValid  (aluValid),
		.aluDest   (aluDest),
		.aluResult (aluResult),
		.wbValid   (wbValid),
		.wbReg     (wbReg),
		.wbData    (wbData)
	);

endmodule

//--- source/resultStage.sv
`timescale 1ns/1ns
`include "pipe_macros.svh"

module resultStage (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       hold,
	input  logic                       flush,
	input  logic                       aluValid,
	input  logic [`REG_ADDR_WIDTH-1:0] aluDest,
	input  logic [`DATA_WIDTH-1:0]     aluResult,
	output logic                       wbValid,
	output logic [`REG_ADDR_WIDTH-1:0] wbReg,
	output logic [`DATA_WIDTH-1:0]     wbData
);

	logic                       resValid;
	logic [`REG_ADDR_WIDTH-1:0] resDest;
	logic [`DATA_WIDTH-1:0]     resData;

	// on flush the current strobe still goes out, the edge then empties the stage
	always_ff @(posedge clk) begin
		if (reset || flush) begin
			resValid <= 1'b0;
			resDest  <= '0;
			resData  <= '0;
		end else if (!hold) begin
			resValid <= aluValid;
			resDest  <= aluDest;
			resData  <= aluResult;
		end
	end

	// held results are strobed once, on the first free cycle
	assign wbValid = resValid && !hold;
	assign wbReg   = resDest;
	assign wbData  = resData;

endmodule

//--- source/executeStage.sv
`timescale 1ns/1ns
`include "pipe_macros.svh"

module executeStage (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       hold,
	input  logic                       flush,
	input  logic                       decValid,
	input  pipePkg::aluOpE             aluOp,
	input  logic [`REG_ADDR_WIDTH-1:0] destReg,
	input  logic [`REG_ADDR_WIDTH-1:0] srcA,
	input  logic [`REG_ADDR_WIDTH-1:0] srcB,
	input  logic [`DATA_WIDTH-1:0]     operandA,
	input  logic [`DATA_WIDTH-1:0]     operandB,
	input  logic [`DATA_WIDTH-1:0]     immediate,
	input  logic [`SHAMT_WIDTH-1:0]    shamt,
	input  logic                       useImm,
	input  logic                       wbValid,
	input  logic [`REG_ADDR_WIDTH-1:0] wbReg,
	input  logic [`DATA_WIDTH-1:0]     wbData,
	output logic                       aluValid,
	output logic [`REG_ADDR_WIDTH-1:0] aluDest,
	output logic [`DATA_WIDTH-1:0]     aluResult
);

	logic                       exValid;
	pipePkg::aluOpE             exAluOp;
	logic [`REG_ADDR_WIDTH-1:0] exDest;
	logic [`REG_ADDR_WIDTH-1:0] exSrcA;
	logic [`REG_ADDR_WIDTH-1:0] exSrcB;
	logic [`DATA_WIDTH-1:0]     exOperandA;
	logic [`DATA_WIDTH-1:0]     exOperandB;
	logic [`DATA_WIDTH-1:0]     exImmediate;
	logic [`SHAMT_WIDTH-1:0]    exShamt;
	logic                       exUseImm;
	logic [`DATA_WIDTH-1:0]     opA;
	logic [`DATA_WIDTH-1:0]     opB;
	logic [`DATA_WIDTH-1:0]     aluB;

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			exValid     <= 1'b0;
			exAluOp     <= pipePkg::ALU_ADD;
			exDest      <= '0;
			exSrcA      <= '0;
			exSrcB      <= '0;
			exOperandA  <= '0;
			exOperandB  <= '0;
			exImmediate <= '0;
			exShamt     <= '0;
			exUseImm    <= 1'b0;
		end else if (!hold) begin
			exValid     <= decValid;
			exAluOp     <= aluOp;
			exDest      <= destReg;
			exSrcA      <= srcA;
			exSrcB      <= srcB;
			exOperandA  <= operandA;
			exOperandB  <= operandB;
			exImmediate <= immediate;
			exShamt     <= shamt;
			exUseImm    <= useImm;
		end
	end

	// operand read in decode may predate the result now writing back
	assign opA  = (wbValid && (wbReg == exSrcA)) ? wbData : exOperandA;
	assign opB  = (wbValid && (wbReg == exSrcB)) ? wbData : exOperandB;
	assign aluB = exUseImm ? exImmediate : opB;

	always_comb begin
		case (exAluOp)
			pipePkg::ALU_ADD: aluResult = opA + aluB;
			pipePkg::ALU_SUB: aluResult = opA - aluB;
			pipePkg::ALU_AND: aluResult = opA & aluB;
			pipePkg::ALU_OR:  aluResult = opA | aluB;
			pipePkg::ALU_XOR: aluResult = opA ^ aluB;
			pipePkg::ALU_SLT: aluResult = {{(`DATA_WIDTH-1){1'b0}}, $signed(opA) < $signed(aluB)};
			pipePkg::ALU_SLL: aluResult = opB << exShamt;
			pipePkg::ALU_LUI: aluResult = exImmediate;
			default:          aluResult = '0;
		endcase
	end

	assign aluValid = exValid;
	assign aluDest  = exDest;

endmodule

//--- decode/decodeStage.sv
`timescale 1ns/1ns
`include "pipe_macros.svh"

module decodeStage (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       hold,
	input  logic                       flush,
	input  logic [`DATA_WIDTH-1:0]     instr,
	input  logic                       instrValid,
	input  logic                       wbValid,
	input  logic [`REG_ADDR_WIDTH-1:0] wbReg,
	input  logic [`DATA_WIDTH-1:0]     wbData,
	output logic                       decValid,
	output pipePkg::aluOpE             aluOp,
	output logic [`REG_ADDR_WIDTH-1:0] destReg,
	output logic [`REG_ADDR_WIDTH-1:0] srcA,
	output logic [`REG_ADDR_WIDTH-1:0] srcB,
	output logic [`DATA_WIDTH-1:0]     operandA,
	output logic [`DATA_WIDTH-1:0]     operandB,
	output logic [`DATA_WIDTH-1:0]     immediate,
	output logic [`SHAMT_WIDTH-1:0]    shamt,
	output logic                       useImm
);

	localparam int IMM_WIDTH = `DATA_WIDTH / 2;

	logic                       validQ;
	pipePkg::opcodeE            opcodeQ;
	pipePkg::functE             functQ;
	logic [`REG_ADDR_WIDTH-1:0] rsQ;
	logic [`REG_ADDR_WIDTH-1:0] rtQ;
	logic [`REG_ADDR_WIDTH-1:0] rdQ;
	logic [`SHAMT_WIDTH-1:0]    shamtQ;
	logic [IMM_WIDTH-1:0]       immQ;
	logic                       known;

	// instruction register, fields sliced on load
	always_ff @(posedge clk) begin
		if (reset || flush) begin
			validQ  <= 1'b0;
			opcodeQ <= pipePkg::OP_SPECIAL;
			functQ  <= pipePkg::FN_SLL;
			rsQ     <= '0;
			rtQ     <= '0;
			rdQ     <= '0;
			shamtQ  <= '0;
			immQ    <= '0;
		end else if (!hold) begin
			validQ  <= instrValid;
			opcodeQ <= pipePkg::opcodeE'(instr[31:26]);
			functQ  <= pipePkg::functE'(instr[5:0]);
			rsQ     <= instr[25:21];
			rtQ     <= instr[20:16];
			rdQ     <= instr[15:11];
			shamtQ  <= instr[10:6];
			immQ    <= instr[15:0];
		end
	end

	always_comb begin
		known     = 1'b1;
		aluOp     = pipePkg::ALU_ADD;
		destReg   = rtQ;
		useImm    = 1'b1;
		immediate = '0;
		case (opcodeQ)
			pipePkg::OP_SPECIAL: begin
				destReg = rdQ;
				useImm  = 1'b0;
				case (functQ)
					pipePkg::FN_ADDU: aluOp = pipePkg::ALU_ADD;
					pipePkg::FN_SUBU: aluOp = pipePkg::ALU_SUB;
					pipePkg::FN_AND:  aluOp = pipePkg::ALU_AND;
					pipePkg::FN_OR:   aluOp = pipePkg::ALU_OR;
					pipePkg::FN_XOR:  aluOp = pipePkg::ALU_XOR;
					pipePkg::FN_SLT:  aluOp = pipePkg::ALU_SLT;
					pipePkg::FN_SLL:  aluOp = pipePkg::ALU_SLL;
					default:          known = 1'b0;
				endcase
			end
			pipePkg::OP_ADDIU: begin
				immediate = {{IMM_WIDTH{immQ[IMM_WIDTH-1]}}, immQ};
			end
			pipePkg::OP_ORI: begin
				aluOp     = pipePkg::ALU_OR;
				immediate = {{IMM_WIDTH{1'b0}}, immQ};
			end
			pipePkg::OP_LUI: begin
				aluOp     = pipePkg::ALU_LUI;
				immediate = {immQ, {IMM_WIDTH{1'b0}}};
			end
			default: known = 1'b0;
		endcase
	end

	// unknown words and writes to r0 become bubbles
	assign decValid = validQ && known && (destReg != '0);
	assign srcA     = rsQ;
	assign srcB     = rtQ;
	assign shamt    = shamtQ;

	registerFile registerFile_inst (
		.clk       (clk),
		.reset     (reset),
		.writeEn   (wbValid),
		.writeReg  (wbReg),
		.writeData (wbData),
		.readRegA  (rsQ),
		.readRegB  (rtQ),
		.readDataA (operandA),
		.readDataB (operandB)
	);

endmodule

//--- decode/registerFile.sv
`timescale 1ns/1ns
`include "pipe_macros.svh"

module registerFile (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       writeEn,
	input  logic [`REG_ADDR_WIDTH-1:0] writeReg,
	input  logic [`DATA_WIDTH-1:0]     writeData,
	input  logic [`REG_ADDR_WIDTH-1:0] readRegA,
	input  logic [`REG_ADDR_WIDTH-1:0] readRegB,
	output logic [`DATA_WIDTH-1:0]     readDataA,
	output logic [`DATA_WIDTH-1:0]     readDataB
);

	// register 0 has no storage
	logic [`DATA_WIDTH-1:0] regs [1:`REG_COUNT-1];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 1; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn && (writeReg != '0)) begin
			regs[writeReg] <= writeData;
		end
	end

	// write-through, so a same-cycle read sees the new value
	always_comb begin
		if (readRegA == '0) begin
			readDataA = '0;
		end else if (writeEn && (writeReg == readRegA)) begin
			readDataA = writeData;
		end else begin
			readDataA = regs[readRegA];
		end
	end

	always_comb begin
		if (readRegB == '0) begin
			readDataB = '0;
		end else if (writeEn && (writeReg == readRegB)) begin
			readDataB = writeData;
		end else begin
			readDataB = regs[readRegB];
		end
	end

endmodule

//--- common/pipePkg.sv
package pipePkg;

	// primary opcode, instr[31:26]
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00,
		OP_ADDIU   = 6'h09,
		OP_ORI     = 6'h0d,
		OP_LUI     = 6'h0f
	} opcodeE;

	// function field of SPECIAL words, instr[5:0]
	typedef enum logic [5:0] {
		FN_SLL  = 6'h00,
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_XOR  = 6'h26,
		FN_SLT  = 6'h2a
	} functE;

	// operation carried from decode into execute
	typedef enum logic [3:0] {
		ALU_ADD = 4'd0,
		ALU_SUB = 4'd1,
		ALU_AND = 4'd2,
		ALU_OR  = 4'd3,
		ALU_XOR = 4'd4,
		ALU_SLT = 4'd5,
		ALU_SLL = 4'd6,
		ALU_LUI = 4'd7
	} aluOpE;

endpackage

//--- common/pipe_macros.svh
`ifndef PIPE_MACROS_SVH
`define PIPE_MACROS_SVH

// instruction and data word
`define DATA_WIDTH 32

// register index and count
`define REG_ADDR_WIDTH 5
`define REG_COUNT 32

// shift amount field of sll
`define SHAMT_WIDTH 5

`endif
